//--- flist.f
rtl/dm_pkg.sv
rtl/dm_dmi_front.sv
rtl/dm_hart_ctrl.sv
rtl/dm_abstract_regs.sv
rtl/dm_csr_top.sv
verif/tb_clkgen.sv
verif/tb_dm_csr.sv

//--- rtl/dm_abstract_regs.sv
// abstract command registers: data, command, abstractcs and cmderr tracking
module dm_abstract_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  dm_pkg::csr_req_t                      csr_req_i,
  output dm_pkg::word_t                         rdata_o,
  input  logic                                  dmactive_i,
  input  logic                                  cmdbusy_i,
  input  logic                                  cmderror_valid_i,
  input  dm_pkg::cmderr_e                       cmderror_i,
  input  dm_pkg::word_t [dm_pkg::DataCount-1:0] data_i,
  input  logic                                  data_valid_i,
  output dm_pkg::word_t [dm_pkg::DataCount-1:0] data_o,
  output logic                                  cmd_valid_o,
  output dm_pkg::word_t                         cmd_o
);

  dm_pkg::word_t [dm_pkg::DataCount-1:0] data_d, data_q;
  dm_pkg::cmderr_e     cmderr_d, cmderr_q;
  dm_pkg::word_t       command_d, command_q;
  logic                cmd_valid_d, cmd_valid_q;
  dm_pkg::abstractcs_t abstractcs;
  dm_pkg::abstractcs_t acs_wdata;
  dm_pkg::dmi_addr_t   data_off;

  logic [$clog2(dm_pkg::DataCount)-1:0] data_idx;
  logic data_hit;
  logic acs_hit;
  logic cmd_hit;
  logic req_rd;
  logic req_wr;
  logic busy;
  logic busy_err;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  // addresses below Data0 wrap to large offsets and miss
  assign data_off = csr_req_i.addr - dm_pkg::AddrData0;
  assign data_idx = data_off[$clog2(dm_pkg::DataCount)-1:0];
  assign data_hit = csr_req_i.valid & (data_off < dm_pkg::dmi_addr_t'(dm_pkg::DataCount));
  assign acs_hit  = csr_req_i.valid & (csr_req_i.addr == dm_pkg::AddrAbstractCs);
  assign cmd_hit  = csr_req_i.valid & (csr_req_i.addr == dm_pkg::AddrCommand);
  assign req_rd   = csr_req_i.valid & ~csr_req_i.write;
  assign req_wr   = csr_req_i.valid & csr_req_i.write;

  assign acs_wdata = dm_pkg::abstractcs_t'(csr_req_i.data);

  // a command counts as running from its issue pulse on
  assign busy     = cmdbusy_i | cmd_valid_q;
  assign busy_err = busy & (data_hit | (req_wr & (acs_hit | cmd_hit)));

  always_comb begin
    data_d      = data_q;
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    if (busy_err) begin
      // first error sticks
      if (cmderr_q == dm_pkg::CmdErrNone) begin
        cmderr_d = dm_pkg::CmdErrBusy;
      end
    end else if (req_wr) begin
      if (data_hit) begin
        data_d[data_idx] = csr_req_i.data;
      end
      if (acs_hit) begin
        // write one to clear
        cmderr_d = dm_pkg::cmderr_e'(cmderr_q & ~acs_wdata.cmderr);
      end
      if (cmd_hit) begin
        command_d   = csr_req_i.data;
        cmd_valid_d = 1'b1;
      end
    end
    // errors from the hart win over the DMI side
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  // --------------------------------------------------
  // read back
  // --------------------------------------------------
  always_comb begin
    abstractcs           = '0;
    abstractcs.datacount = 4'(dm_pkg::DataCount);
    abstractcs.busy      = busy;
    abstractcs.cmderr    = cmderr_q;
  end

  always_comb begin
    rdata_o = '0;
    if (req_rd) begin
      if (data_hit) begin
        rdata_o = data_q[data_idx];
      end else if (acs_hit) begin
        rdata_o = abstractcs;
      end
    end
  end

  assign data_o      = data_q;
  assign cmd_o       = command_q;
  assign cmd_valid_o = cmd_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q      <= '0;
      cmderr_q    <= dm_pkg::CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      data_q      <= '0;
      cmderr_q    <= dm_pkg::CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      data_q      <= data_d;
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  a_cmd_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

//--- rtl/dm_csr_top.sv
// debug module register block top: DMI front end, hart control and abstract registers
module dm_csr_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // DMI channel
  input  logic                                  dmi_req_valid_i,
  input  dm_pkg::dmi_req_t                      dmi_req_i,
  output logic                                  dmi_req_ready_o,
  output logic                                  dmi_resp_valid_o,
  output dm_pkg::dmi_resp_t                     dmi_resp_o,
  input  logic                                  dmi_resp_ready_i,
  // hart status
  input  dm_pkg::hart_vec_t                     halted_i,
  input  dm_pkg::hart_vec_t                     unavailable_i,
  input  dm_pkg::hart_vec_t                     resumeack_i,
  // hart requests
  output dm_pkg::hart_vec_t                     haltreq_o,
  output dm_pkg::hart_vec_t                     resumereq_o,
  output logic                                  clear_resumeack_o,
  output logic                                  ndmreset_o,
  output logic                                  dmactive_o,
  // abstract commands
  input  logic                                  cmdbusy_i,
  input  logic                                  cmderror_valid_i,
  input  dm_pkg::cmderr_e                       cmderror_i,
  input  dm_pkg::word_t [dm_pkg::DataCount-1:0] data_i,
  input  logic                                  data_valid_i,
  output dm_pkg::word_t [dm_pkg::DataCount-1:0] data_o,
  output logic                                  cmd_valid_o,
  output dm_pkg::word_t                         cmd_o
);

  dm_pkg::csr_req_t csr_req;
  dm_pkg::word_t    ctrl_rdata;
  dm_pkg::word_t    abs_rdata;

  dm_dmi_front u_dmi_front (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_i        (dmi_req_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_o       (dmi_resp_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .csr_req_o        (csr_req),
    .ctrl_rdata_i     (ctrl_rdata),
    .abs_rdata_i      (abs_rdata)
  );

  dm_hart_ctrl u_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_req_i         (csr_req),
    .rdata_o           (ctrl_rdata),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_regs u_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .csr_req_i        (csr_req),
    .rdata_o          (abs_rdata),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_i           (data_i),
    .data_valid_i     (data_valid_i),
    .data_o           (data_o),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o)
  );

endmodule

//--- rtl/dm_dmi_front.sv
// DMI front end: request accept, read data merge and two-entry response FIFO
module dm_dmi_front (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dmi_req_valid_i,
  input  dm_pkg::dmi_req_t  dmi_req_i,
  output logic              dmi_req_ready_o,
  output logic              dmi_resp_valid_o,
  output dm_pkg::dmi_resp_t dmi_resp_o,
  input  logic              dmi_resp_ready_i,
  output dm_pkg::csr_req_t  csr_req_o,
  input  dm_pkg::word_t     ctrl_rdata_i,
  input  dm_pkg::word_t     abs_rdata_i
);

  logic          accept;
  logic          pop;
  logic          full;
  logic          empty;
  logic          wr_ptr_q;
  logic          rd_ptr_q;
  logic [1:0]    count_q;
  dm_pkg::word_t push_data;
  dm_pkg::word_t mem_q [2];

  // every accepted request pushes exactly one response
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_req_ready_o = ~full;

  // nop requests never reach the register blocks
  assign csr_req_o.valid = accept & ((dmi_req_i.op == dm_pkg::DtmRead) |
                                     (dmi_req_i.op == dm_pkg::DtmWrite));
  assign csr_req_o.write = dmi_req_i.op == dm_pkg::DtmWrite;
  assign csr_req_o.addr  = dmi_req_i.addr;
  assign csr_req_o.data  = dmi_req_i.data;

  // blocks return zero for foreign addresses and writes
  assign push_data = ctrl_rdata_i | abs_rdata_i;

  // --------------------------------------------------
  // response FIFO
  // --------------------------------------------------
  assign full             = count_q == 2'd2;
  assign empty            = count_q == 2'd0;
  assign dmi_resp_valid_o = ~empty;
  assign pop              = dmi_resp_valid_o & dmi_resp_ready_i;
  assign dmi_resp_o.data  = mem_q[rd_ptr_q];
  // success code
  assign dmi_resp_o.resp  = 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (accept) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({accept, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[wr_ptr_q] <= push_data;
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full && !pop |=> full && $stable(wr_ptr_q));
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty && !accept |=> empty && $stable(rd_ptr_q));

endmodule

//--- rtl/dm_hart_ctrl.sv
// dmcontrol and havereset registers, dmstatus view and per-hart request outputs
module dm_hart_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dm_pkg::csr_req_t  csr_req_i,
  output dm_pkg::word_t     rdata_o,
  input  dm_pkg::hart_vec_t halted_i,
  input  dm_pkg::hart_vec_t unavailable_i,
  input  dm_pkg::hart_vec_t resumeack_i,
  output dm_pkg::hart_vec_t haltreq_o,
  output dm_pkg::hart_vec_t resumereq_o,
  output logic              clear_resumeack_o,
  output logic              ndmreset_o,
  output logic              dmactive_o
);

  dm_pkg::dmcontrol_t dmcontrol_d, dmcontrol_q;
  dm_pkg::dmcontrol_t wdata;
  dm_pkg::dmstatus_t  dmstatus;
  dm_pkg::hart_vec_t  havereset_d, havereset_q;

  logic [$clog2(dm_pkg::NrHarts)-1:0] sel_idx;
  logic [$clog2(dm_pkg::NrHarts)-1:0] ack_idx;
  logic sel_exists;
  logic ack_exists;
  logic ctrl_wr;
  logic sel_halted;
  logic sel_running;
  logic sel_unavail;

  assign wdata   = dm_pkg::dmcontrol_t'(csr_req_i.data);
  assign ctrl_wr = csr_req_i.valid & csr_req_i.write &
                   (csr_req_i.addr == dm_pkg::AddrDmControl);

  // hart currently selected
  assign sel_idx    = dmcontrol_q.hartsello[$clog2(dm_pkg::NrHarts)-1:0];
  assign sel_exists = dmcontrol_q.hartsello < dm_pkg::hartsel_t'(dm_pkg::NrHarts);
  // ackhavereset applies to the hart named in the same write
  assign ack_idx    = wdata.hartsello[$clog2(dm_pkg::NrHarts)-1:0];
  assign ack_exists = wdata.hartsello < dm_pkg::hartsel_t'(dm_pkg::NrHarts);

  // --------------------------------------------------
  // dmcontrol and havereset next state
  // --------------------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    if (ctrl_wr) begin
      dmcontrol_d = wdata;
    end
    // auto-clear once the selected hart acknowledges
    if (dmcontrol_q.resumereq && sel_exists && resumeack_i[sel_idx]) begin
      dmcontrol_d.resumereq = 1'b0;
    end
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.hartselhi       = '0;
    dmcontrol_d.zero0           = '0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;
    // inactive module keeps nothing but dmactive itself
    if (!dmcontrol_d.dmactive) begin
      dmcontrol_d = '0;
    end

    havereset_d = havereset_q;
    if (ctrl_wr && wdata.ackhavereset && ack_exists) begin
      havereset_d[ack_idx] = 1'b0;
    end
    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end
  end

  assign clear_resumeack_o = ctrl_wr & ~dmcontrol_q.resumereq & dmcontrol_d.resumereq;

  // --------------------------------------------------
  // dmstatus for the selected hart
  // --------------------------------------------------
  assign sel_unavail = sel_exists & unavailable_i[sel_idx];
  assign sel_halted  = sel_exists & halted_i[sel_idx] & ~unavailable_i[sel_idx];
  assign sel_running = sel_exists & ~halted_i[sel_idx] & ~unavailable_i[sel_idx];

  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = dm_pkg::DbgVersion;
    // no authentication
    dmstatus.authenticated  = 1'b1;
    dmstatus.allnonexistent = ~sel_exists;
    dmstatus.anynonexistent = ~sel_exists;
    dmstatus.allhavereset   = sel_exists & havereset_q[sel_idx];
    dmstatus.anyhavereset   = sel_exists & havereset_q[sel_idx];
    dmstatus.allresumeack   = sel_exists & resumeack_i[sel_idx];
    dmstatus.anyresumeack   = sel_exists & resumeack_i[sel_idx];
    dmstatus.allunavail     = sel_unavail;
    dmstatus.anyunavail     = sel_unavail;
    dmstatus.allhalted      = sel_halted;
    dmstatus.anyhalted      = sel_halted;
    dmstatus.allrunning     = sel_running;
    dmstatus.anyrunning     = sel_running;
  end

  always_comb begin
    rdata_o = '0;
    if (csr_req_i.valid && !csr_req_i.write) begin
      case (csr_req_i.addr)
        dm_pkg::AddrDmControl: rdata_o = dmcontrol_q;
        dm_pkg::AddrDmStatus:  rdata_o = dmstatus;
        default:               rdata_o = '0;
      endcase
    end
  end

  // one-hot requests towards the selected hart
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel_idx]   = dmcontrol_q.haltreq;
      resumereq_o[sel_idx] = dmcontrol_q.resumereq;
    end
  end

  assign ndmreset_o = dmcontrol_q.ndmreset;
  assign dmactive_o = dmcontrol_q.dmactive;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  // a halt request only ever reaches one hart, and only while active
  a_haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o) && (haltreq_o == '0 || dmactive_o));

endmodule

//--- rtl/dm_pkg.sv
// debug module package: sizes, DMI register map, field layouts and error codes
package dm_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned NrHarts    = 4;
  localparam int unsigned DataCount  = 2;
  // version 2 is debug spec 0.13
  localparam logic [3:0]  DbgVersion = 4'd2;

  typedef logic [6:0]         dmi_addr_t;
  typedef logic [31:0]        word_t;
  typedef logic [9:0]         hartsel_t;
  typedef logic [NrHarts-1:0] hart_vec_t;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  localparam dmi_addr_t AddrData0      = 7'h04;
  localparam dmi_addr_t AddrDmControl  = 7'h10;
  localparam dmi_addr_t AddrDmStatus   = 7'h11;
  localparam dmi_addr_t AddrAbstractCs = 7'h16;
  localparam dmi_addr_t AddrCommand    = 7'h17;

  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // --------------------------------------------------
  // channel and register layouts
  // --------------------------------------------------
  typedef struct packed {
    dmi_addr_t addr;
    word_t     data;
    dtm_op_e   op;
  } dmi_req_t;

  typedef struct packed {
    word_t      data;
    logic [1:0] resp;
  } dmi_resp_t;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    hartsel_t   hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       confstrptrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  // accepted DMI request as seen by the register blocks
  typedef struct packed {
    logic      valid;
    logic      write;
    dmi_addr_t addr;
    word_t     data;
  } csr_req_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the debug module register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_dm_csr -Mdir obj_dir \
  && ./obj_dir/Vtb_dm_csr | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -qx "sim passed" sim.log && exit 0 || exit 1

//--- verif/tb_clkgen.sv
// testbench clock and active-low reset generator
module tb_clkgen #(
  parameter int ClkPeriod   = 20,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- verif/tb_dm_csr.sv
// testbench top: DMI driver tasks, directed register tests, watchdog and summary
module tb_dm_csr;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod     = 20;
  localparam int ResetCycles   = 16;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 200;

  // spec bit positions of dmcontrol
  localparam int CtrlDmActive     = 0;
  localparam int CtrlHartSelLsb   = 16;
  localparam int CtrlAckHaveReset = 28;
  localparam int CtrlResumeReq    = 30;
  localparam int CtrlHaltReq      = 31;
  // spec bit positions of dmstatus
  localparam int StAuth         = 7;
  localparam int StAllHalted    = 9;
  localparam int StAllRunning   = 11;
  localparam int StAnyNonexist  = 14;
  localparam int StAllNonexist  = 15;
  localparam int StAnyHaveReset = 18;
  localparam int StAllHaveReset = 19;

  logic clk;
  logic rst_n;

  logic                                  dmi_req_valid;
  dm_pkg::dmi_req_t                      dmi_req;
  logic                                  dmi_req_ready;
  logic                                  dmi_resp_valid;
  dm_pkg::dmi_resp_t                     dmi_resp;
  logic                                  dmi_resp_ready;
  dm_pkg::hart_vec_t                     halted;
  dm_pkg::hart_vec_t                     unavailable;
  dm_pkg::hart_vec_t                     resumeack;
  dm_pkg::hart_vec_t                     haltreq;
  dm_pkg::hart_vec_t                     resumereq;
  logic                                  clear_resumeack;
  logic                                  ndmreset;
  logic                                  dmactive;
  logic                                  cmdbusy;
  logic                                  cmderror_valid;
  dm_pkg::cmderr_e                       cmderror;
  dm_pkg::word_t [dm_pkg::DataCount-1:0] data_in;
  logic                                  data_valid;
  dm_pkg::word_t [dm_pkg::DataCount-1:0] data_out;
  logic                                  cmd_valid;
  dm_pkg::word_t                         cmd;

  int            errors;
  int            checks;
  int            cmd_pulses;
  dm_pkg::word_t cmd_seen;
  logic          clr_at_accept;

  tb_clkgen #(.ClkPeriod(ClkPeriod), .ResetCycles(ResetCycles)) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dm_csr_top dut_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .dmi_req_valid_i   (dmi_req_valid),
    .dmi_req_i         (dmi_req),
    .dmi_req_ready_o   (dmi_req_ready),
    .dmi_resp_valid_o  (dmi_resp_valid),
    .dmi_resp_o        (dmi_resp),
    .dmi_resp_ready_i  (dmi_resp_ready),
    .halted_i          (halted),
    .unavailable_i     (unavailable),
    .resumeack_i       (resumeack),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .clear_resumeack_o (clear_resumeack),
    .ndmreset_o        (ndmreset),
    .dmactive_o        (dmactive),
    .cmdbusy_i         (cmdbusy),
    .cmderror_valid_i  (cmderror_valid),
    .cmderror_i        (cmderror),
    .data_i            (data_in),
    .data_valid_i      (data_valid),
    .data_o            (data_out),
    .cmd_valid_o       (cmd_valid),
    .cmd_o             (cmd)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic check_eq(input string name, input dm_pkg::word_t got,
                          input dm_pkg::word_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic dm_pkg::word_t ctrl_word(input int hartsel, input bit halt,
                                              input bit resume, input bit ack,
                                              input bit active);
    dm_pkg::word_t w;
    w                             = '0;
    w[CtrlHartSelLsb +: 10]       = hartsel[9:0];
    w[CtrlHaltReq]                = halt;
    w[CtrlResumeReq]              = resume;
    w[CtrlAckHaveReset]           = ack;
    w[CtrlDmActive]               = active;
    return w;
  endfunction

  // datacount 2 in [3:0], cmderr in [10:8], busy at 12
  function automatic dm_pkg::word_t acs_word(input bit busy, input int err);
    return (32'(busy) << 12) | (32'(err[2:0]) << 8) | 32'd2;
  endfunction

  // drive one request and hold it until the DUT accepts it
  task automatic dmi_send(input dm_pkg::dtm_op_e op, input dm_pkg::dmi_addr_t addr,
                          input dm_pkg::word_t wdata);
    @(negedge clk);
    dmi_req_valid = 1'b1;
    dmi_req.addr  = addr;
    dmi_req.data  = wdata;
    dmi_req.op    = op;
    #1;
    while (!dmi_req_ready) begin
      @(negedge clk);
      #1;
    end
    // value during the accept cycle
    clr_at_accept = clear_resumeack;
    @(negedge clk);
    dmi_req_valid = 1'b0;
  endtask

  task automatic dmi_recv(output dm_pkg::word_t rdata);
    while (!(dmi_resp_valid && dmi_resp_ready)) @(negedge clk);
    rdata = dmi_resp.data;
    check_eq("dmi_resp.resp", 32'(dmi_resp.resp), 32'd0);
    // entry pops at the next rising edge
    @(negedge clk);
  endtask

  task automatic dmi_access(input dm_pkg::dtm_op_e op, input dm_pkg::dmi_addr_t addr,
                            input dm_pkg::word_t wdata, output dm_pkg::word_t rdata);
    dmi_send(op, addr, wdata);
    dmi_recv(rdata);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    dm_pkg::word_t rd;
    @(negedge clk);
    check_eq("dmi_resp_valid_o", 32'(dmi_resp_valid), 32'd0);
    check_eq("dmi_req_ready_o", 32'(dmi_req_ready), 32'd1);
    check_eq("cmd_valid_o", 32'(cmd_valid), 32'd0);
    check_eq("clear_resumeack_o", 32'(clear_resumeack), 32'd0);
    check_eq("haltreq_o", 32'(haltreq), 32'd0);
    check_eq("resumereq_o", 32'(resumereq), 32'd0);
    check_eq("ndmreset_o", 32'(ndmreset), 32'd0);
    check_eq("dmactive_o", 32'(dmactive), 32'd0);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmStatus, '0, rd);
    check_eq("dmstatus.version", 32'(rd[3:0]), 32'd2);
    check_eq("dmstatus.authenticated", 32'(rd[StAuth]), 32'd1);
    check_eq("dmstatus.allhavereset", 32'(rd[StAllHaveReset]), 32'd1);
    check_eq("dmstatus.anyhavereset", 32'(rd[StAnyHaveReset]), 32'd1);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmControl, '0, rd);
    check_eq("dmcontrol", rd, 32'd0);
  endtask

  task automatic test_hart_select();
    dm_pkg::word_t rd;
    halted = 4'b0100;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(2, 1, 0, 0, 1), rd);
    check_eq("haltreq_o", 32'(haltreq), 32'h4);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmStatus, '0, rd);
    check_eq("dmstatus.allhalted", 32'(rd[StAllHalted]), 32'd1);
    check_eq("dmstatus.allrunning", 32'(rd[StAllRunning]), 32'd0);
    check_eq("dmstatus.allhavereset", 32'(rd[StAllHaveReset]), 32'd1);
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(2, 1, 0, 1, 1), rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmStatus, '0, rd);
    check_eq("dmstatus.allhavereset", 32'(rd[StAllHaveReset]), 32'd0);
    // hart 5 does not exist and must not alias onto hart 1
    halted = '1;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(5, 1, 0, 0, 1), rd);
    check_eq("haltreq_o", 32'(haltreq), 32'd0);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmStatus, '0, rd);
    check_eq("dmstatus.allnonexistent", 32'(rd[StAllNonexist]), 32'd1);
    check_eq("dmstatus.anynonexistent", 32'(rd[StAnyNonexist]), 32'd1);
    check_eq("dmstatus.allhalted", 32'(rd[StAllHalted]), 32'd0);
    check_eq("dmstatus.allhavereset", 32'(rd[StAllHaveReset]), 32'd0);
    halted = '0;
  endtask

  task automatic test_resume();
    dm_pkg::word_t rd;
    dmi_send(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(1, 0, 1, 0, 1));
    check_eq("clear_resumeack_o", 32'(clr_at_accept), 32'd1);
    check_eq("resumereq_o", 32'(resumereq), 32'h2);
    dmi_recv(rd);
    resumeack = 4'b0010;
    @(negedge clk);
    check_eq("resumereq_o", 32'(resumereq), 32'd0);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrDmControl, '0, rd);
    check_eq("dmcontrol", rd, ctrl_word(1, 0, 0, 0, 1));
    resumeack = '0;
  endtask

  task automatic test_abstract_cmd();
    dm_pkg::word_t rd;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(0, 0, 0, 0, 1), rd);
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrData0, 32'ha5c3_1e77, rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrData0, '0, rd);
    check_eq("data0", rd, 32'ha5c3_1e77);
    check_eq("data_o[0]", data_out[0], 32'ha5c3_1e77);
    cmd_pulses = 0;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrCommand, 32'h0022_1002, rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrCommand, '0, rd);
    check_eq("command", rd, 32'd0);
    check_eq("cmd_valid_o pulses", 32'(cmd_pulses), 32'd1);
    check_eq("cmd_o", cmd_seen, 32'h0022_1002);
    // inactive module drops its state
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, '0, rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrData0, '0, rd);
    check_eq("data0", rd, 32'd0);
    check_eq("data_o[0]", data_out[0], 32'd0);
  endtask

  task automatic test_cmd_errors();
    dm_pkg::word_t rd;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrDmControl, ctrl_word(0, 0, 0, 0, 1), rd);
    cmdbusy = 1'b1;
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrData0, 32'h1234_5678, rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrAbstractCs, '0, rd);
    check_eq("abstractcs", rd, acs_word(1, 1));
    cmdbusy = 1'b0;
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrData0, '0, rd);
    check_eq("data0", rd, 32'd0);
    dmi_access(dm_pkg::DtmWrite, dm_pkg::AddrAbstractCs, 32'h0000_0700, rd);
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrAbstractCs, '0, rd);
    check_eq("abstractcs", rd, acs_word(0, 0));
    // exception reported by the hart
    @(negedge clk);
    cmderror_valid = 1'b1;
    cmderror       = dm_pkg::CmdErrException;
    @(negedge clk);
    cmderror_valid = 1'b0;
    dmi_access(dm_pkg::DtmRead, dm_pkg::AddrAbstractCs, '0, rd);
    check_eq("abstractcs", rd, acs_word(0, 3));
  endtask

  task automatic test_back_pressure();
    dm_pkg::word_t rd;
    dmi_resp_ready = 1'b0;
    dmi_send(dm_pkg::DtmRead, dm_pkg::AddrDmControl, '0);
    dmi_send(dm_pkg::DtmRead, dm_pkg::AddrAbstractCs, '0);
    check_eq("dmi_req_ready_o", 32'(dmi_req_ready), 32'd0);
    check_eq("dmi_resp_valid_o", 32'(dmi_resp_valid), 32'd1);
    dmi_resp_ready = 1'b1;
    dmi_recv(rd);
    check_eq("first response", rd, ctrl_word(0, 0, 0, 0, 1));
    dmi_recv(rd);
    check_eq("second response", rd, acs_word(0, 3));
    check_eq("dmi_req_ready_o", 32'(dmi_req_ready), 32'd1);
  endtask

  // --------------------------------------------------
  // monitor, watchdog and main sequence
  // --------------------------------------------------
  always @(negedge clk) begin
    if (rst_n && cmd_valid) begin
      cmd_pulses++;
      cmd_seen = cmd;
    end
  end

  initial begin
    #((ResetCycles + NumTests * CyclesPerTest) * ClkPeriod);
    $display("timeout: tests did not finish within %0d cycles", NumTests * CyclesPerTest);
    $display("sim failed");
    $finish;
  end

  initial begin
    dmi_req_valid  = 1'b0;
    dmi_req        = '0;
    dmi_resp_ready = 1'b1;
    halted         = '0;
    unavailable    = '0;
    resumeack      = '0;
    cmdbusy        = 1'b0;
    cmderror_valid = 1'b0;
    cmderror       = dm_pkg::CmdErrNone;
    data_in        = '0;
    data_valid     = 1'b0;
    errors         = 0;
    checks         = 0;
    cmd_pulses     = 0;
    cmd_seen       = '0;
    clr_at_accept  = 1'b0;
    wait (rst_n === 1'b1);
    test_reset_state();
    test_hart_select();
    test_resume();
    test_abstract_cmd();
    test_cmd_errors();
    test_back_pressure();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
